// ==== hdl/taylor_types_pkg.sv ====
package taylor_types_pkg;

	localparam int SAMPLE_W = 19;
	localparam int COEF_W = 28;
	localparam int RESULT_W = 28;
	localparam int TAG_W = 8;
	localparam int CORE_ID_W = 2;

	// Q2.16 input sample
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// Q11.16 coefficient
	typedef logic signed [COEF_W-1:0] coef_t;

	// Polynomial value, wraps at this width
	typedef logic signed [RESULT_W-1:0] result_t;

	typedef logic [TAG_W-1:0] tag_t;          // Sequence number, given at acceptance
	typedef logic [CORE_ID_W-1:0] core_id_t;  // Core index

	// Full product of accumulator and sample, before rescaling
	typedef logic signed [RESULT_W+SAMPLE_W-1:0] prod_t;

	// Work item handed from the dispatcher to a core
	typedef struct packed {
		tag_t tag;
		sample_t x;
	} job_t;

	// Finished result of one core
	typedef struct packed {
		core_id_t core_id;
		tag_t tag;
		result_t value;
	} result_msg_t;

	typedef enum logic [1:0] {
		core_idle,
		core_compute,
		core_done
	} core_state_e;

endpackage

// ==== hdl/multicore_cfg_pkg.sv ====
package multicore_cfg_pkg;

	import taylor_types_pkg::*;

	localparam int NUM_CORES = 4;
	localparam int RELEASE_GAP = 17;  // Cycles between successive core enables
	localparam int FRAC_BITS = 16;
	localparam int ORDER = 3;         // Polynomial degree

	localparam int GAP_W = $clog2(RELEASE_GAP);
	localparam int REL_W = $clog2(NUM_CORES + 1);
	localparam int STEP_W = $clog2(ORDER + 1);

	// Row per core, c0 first
	localparam coef_t COEFS [NUM_CORES][ORDER+1] = '{
		'{28'sh001_0000, 28'sh001_0000, 28'sh000_8000, 28'sh000_2aab},   // exp(x)
		'{28'sh000_0000, 28'sh001_0000, 28'sh000_0000, -28'sh000_2aab},  // sin(x)
		'{28'sh001_0000, 28'sh000_0000, -28'sh000_8000, 28'sh000_0000},  // cos(x)
		'{28'sh000_0000, 28'sh001_0000, -28'sh000_8000, 28'sh000_5555}   // ln(1+x)
	};

endpackage

// ==== hdl/release_sequencer.sv ====
`timescale 1ns/1ps

module release_sequencer (
	input logic clk,
	input logic rst,
	output logic [multicore_cfg_pkg::NUM_CORES-1:0] enable
);

	import multicore_cfg_pkg::*;

	logic [GAP_W-1:0] gap_cnt;   // Cycles since the last release
	logic [REL_W-1:0] released;  // Number of cores enabled so far
	logic all_released;

	assign all_released = (released == REL_W'(NUM_CORES));

	always_ff @(posedge clk) begin
		if (rst) begin
			gap_cnt <= '0;
			released <= '0;
		end else if (!all_released) begin
			if (gap_cnt == GAP_W'(RELEASE_GAP - 1)) begin
				gap_cnt <= '0;
				released <= released + 1'b1;  // Next core comes out of hold
			end else begin
				gap_cnt <= gap_cnt + 1'b1;
			end
		end
	end

	// Thermometer decode, core i runs once more than i cores are released
	always_comb begin
		for (int i = 0; i < NUM_CORES; i++) begin
			enable[i] = (int'(released) > i);
		end
	end

endmodule

// ==== hdl/job_dispatcher.sv ====
`timescale 1ns/1ps

module job_dispatcher (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input taylor_types_pkg::sample_t in_sample,
	output logic in_ready,
	input logic [multicore_cfg_pkg::NUM_CORES-1:0] enable,
	input logic [multicore_cfg_pkg::NUM_CORES-1:0] busy,
	output logic [multicore_cfg_pkg::NUM_CORES-1:0] start,
	output taylor_types_pkg::job_t job
);

	import taylor_types_pkg::*;
	import multicore_cfg_pkg::*;

	logic found;
	core_id_t sel;
	tag_t tag_cnt;
	logic accept;

	// Lowest enabled core that is free
	always_comb begin
		found = 1'b0;
		sel = '0;
		for (int i = 0; i < NUM_CORES; i++) begin
			if (!found && enable[i] && !busy[i]) begin
				found = 1'b1;
				sel = core_id_t'(i);
			end
		end
	end

	assign in_ready = found;
	assign accept = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			start <= '0;
			tag_cnt <= '0;
		end else begin
			start <= '0;  // One cycle pulse
			if (accept) begin
				start[sel] <= 1'b1;
				tag_cnt <= tag_cnt + 1'b1;
			end
		end
	end

	// Shared job, the started core latches it with start
	always_ff @(posedge clk) begin
		if (accept) begin
			job.tag <= tag_cnt;
			job.x <= in_sample;
		end
	end

endmodule

// ==== hdl/taylor_core.sv ====
`timescale 1ns/1ps

module taylor_core #(
	parameter int CORE_ID = 0
) (
	input logic clk,
	input logic rst,
	input logic start,
	input taylor_types_pkg::job_t job,
	input logic grant,
	output logic busy,
	output logic done,
	output taylor_types_pkg::result_msg_t msg
);

	import taylor_types_pkg::*;
	import multicore_cfg_pkg::*;

	core_state_e state;
	logic [STEP_W-1:0] step;  // Index of the coefficient added next
	sample_t x;
	tag_t tag;
	result_t acc;
	prod_t prod;
	prod_t scaled;
	result_t next_acc;

	// One Horner step: acc*x rescaled, plus the next lower coefficient
	assign prod = acc * x;
	assign scaled = prod >>> FRAC_BITS;
	assign next_acc = scaled[RESULT_W-1:0] + COEFS[CORE_ID][step];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= core_idle;
			step <= '0;
		end else begin
			case (state)
				core_idle: begin
					if (start) begin
						state <= core_compute;
						step <= STEP_W'(ORDER - 1);
					end
				end
				core_compute: begin
					step <= step - 1'b1;
					if (step == '0) begin
						state <= core_done;  // c0 added this cycle
					end
				end
				core_done: begin
					if (grant) begin
						state <= core_idle;
					end
				end
				default: state <= core_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == core_idle && start) begin
			acc <= COEFS[CORE_ID][ORDER];  // Start from the highest coefficient
			x <= job.x;
			tag <= job.tag;
		end else if (state == core_compute) begin
			acc <= next_acc;
		end
	end

	// Busy covers the start cycle so the dispatcher skips this core at once
	assign busy = (state != core_idle) || start;
	assign done = (state == core_done);

	assign msg.core_id = core_id_t'(CORE_ID);
	assign msg.tag = tag;
	assign msg.value = acc;  // Held until grant

endmodule

// ==== hdl/result_arbiter.sv ====
`timescale 1ns/1ps

module result_arbiter (
	input logic clk,
	input logic rst,
	input logic [multicore_cfg_pkg::NUM_CORES-1:0] done,
	input taylor_types_pkg::result_msg_t msgs [multicore_cfg_pkg::NUM_CORES],
	output logic [multicore_cfg_pkg::NUM_CORES-1:0] grant,
	output logic out_valid,
	output taylor_types_pkg::result_msg_t out_msg
);

	import taylor_types_pkg::*;
	import multicore_cfg_pkg::*;

	logic found;
	core_id_t sel;

	// Fixed priority, lowest index wins
	always_comb begin
		found = 1'b0;
		sel = '0;
		grant = '0;
		for (int i = 0; i < NUM_CORES; i++) begin
			if (!found && done[i]) begin
				found = 1'b1;
				sel = core_id_t'(i);
				grant[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= found;  // One pulse per granted result
		end
	end

	always_ff @(posedge clk) begin
		if (found) begin
			out_msg <= msgs[sel];
		end
	end

endmodule

// ==== hdl/multicore.sv ====
`timescale 1ns/1ps

module multicore (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input taylor_types_pkg::sample_t in_sample,
	output logic in_ready,
	output logic out_valid,
	output taylor_types_pkg::result_msg_t out_msg
);

	import taylor_types_pkg::*;
	import multicore_cfg_pkg::*;

	logic [NUM_CORES-1:0] enable;
	logic [NUM_CORES-1:0] busy;
	logic [NUM_CORES-1:0] start;
	logic [NUM_CORES-1:0] done;
	logic [NUM_CORES-1:0] grant;
	job_t job;                       // Shared by all cores
	result_msg_t msgs [NUM_CORES];

	release_sequencer seq0 (
		.clk(clk),
		.rst(rst),
		.enable(enable)
	);

	job_dispatcher disp0 (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_sample(in_sample),
		.in_ready(in_ready),
		.enable(enable),
		.busy(busy),
		.start(start),
		.job(job)
	);

	for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
		taylor_core #(
			.CORE_ID(i)
		) core_inst (
			.clk(clk),
			.rst(rst),
			.start(start[i]),
			.job(job),
			.grant(grant[i]),
			.busy(busy[i]),
			.done(done[i]),
			.msg(msgs[i])
		);
	end

	result_arbiter arb0 (
		.clk(clk),
		.rst(rst),
		.done(done),
		.msgs(msgs),
		.grant(grant),
		.out_valid(out_valid),
		.out_msg(out_msg)
	);

endmodule

// ==== testbench/multicore_assertions.sv ====
`timescale 1ns/1ps

module multicore_assertions (
	input logic clk,
	input logic rst,
	input logic in_ready,
	input logic out_valid,
	input logic [multicore_cfg_pkg::NUM_CORES-1:0] enable,
	input logic [multicore_cfg_pkg::NUM_CORES-1:0] grant
);

	int failures = 0;  // Assertion failures so far

	// Output register is cleared on every reset edge
	out_quiet_in_reset: assert property (@(posedge clk) rst |=> !out_valid)
		else begin
			failures++;
			$error("out_valid high while rst is held");
		end

	ready_needs_enable: assert property (
		@(posedge clk) disable iff (rst) (enable == '0) |-> !in_ready
	) else begin
		failures++;
		$error("in_ready high with no core enabled");
	end

	grant_one_hot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
		else begin
			failures++;
			$error("grant given to more than one core");
		end

endmodule

// ==== testbench/multicore_tb.sv ====
`timescale 1ns/1ps

module multicore_tb;

	import taylor_types_pkg::*;
	import multicore_cfg_pkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int RELEASE_SAMPLES = 40;  // Back to back from reset on
	localparam int GAP_SAMPLES = 100;     // Random idle cycles in between
	localparam int BURST_SAMPLES = 60;
	localparam int TOTAL_SAMPLES = RELEASE_SAMPLES + GAP_SAMPLES + BURST_SAMPLES;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_CORES * RELEASE_GAP
		+ TOTAL_SAMPLES * (ORDER + 4) * NUM_CORES + 200;

	logic clk;
	logic rst;
	logic in_valid;
	sample_t in_sample;
	logic in_ready;
	logic out_valid;
	result_msg_t out_msg;

	logic [31:0] lfsr_state;
	sample_t sent_sample [256];  // Indexed by tag
	logic pending [256];
	int next_tag;
	int burst_first_tag;
	int accepted;
	int returned;
	int edges;  // Rising edges since reset release
	logic [NUM_CORES-1:0] burst_cores;
	int value_errors;
	int tag_errors;
	int other_errors;

	multicore dut0 (
		.clk(clk),
		.rst(rst),
		.in_valid(in_valid),
		.in_sample(in_sample),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_msg(out_msg)
	);

	bind multicore multicore_assertions asrt0 (
		.clk(clk),
		.rst(rst),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.enable(enable),
		.grant(grant)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // x^32 + x^22 + x^2 + x + 1
		return {s[30:0], fb};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] bits);
		int k;
		bits = '0;
		for (k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			bits = {bits[30:0], lfsr_state[0]};
		end
	endtask

	// Horner from c3 down, wrapping at 28 bits after each step
	function automatic result_t ref_poly(input int core, input sample_t x);
		longint acc;
		longint prod;
		result_t wrapped;
		int k;
		acc = longint'(COEFS[core][ORDER]);
		for (k = ORDER - 1; k >= 0; k--) begin
			prod = acc * longint'(x);
			prod = prod >>> FRAC_BITS;
			wrapped = result_t'(prod + longint'(COEFS[core][k]));
			acc = longint'(wrapped);
		end
		return result_t'(acc);
	endfunction

	// Cores released after e edges, core i comes up at (i+1)*gap
	function automatic int enabled_after(input int e);
		int n;
		int i;
		n = 0;
		for (i = 0; i < NUM_CORES; i++) begin
			if ((i + 1) * RELEASE_GAP <= e) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic send_sample(input sample_t s, output int waited);
		waited = 0;
		in_valid = 1'b1;
		in_sample = s;
		while (!in_ready) begin
			@(negedge clk);
			waited++;
		end
		sent_sample[next_tag % 256] = s;  // Taken on the coming edge
		pending[next_tag % 256] = 1'b1;
		next_tag++;
		@(negedge clk);
	endtask

	task automatic idle_cycles(input int n);
		in_valid = 1'b0;
		repeat (n) @(negedge clk);
	endtask

	task automatic check_result();
		result_t expected;
		int id;
		int tag;
		id = int'(out_msg.core_id);
		tag = int'(out_msg.tag);
		returned++;
		if (id >= enabled_after(edges)) begin
			$display("ERROR core_id not yet released: core_id=%h enabled=%h tag=%h",
				out_msg.core_id, enabled_after(edges), out_msg.tag);
			other_errors++;
		end
		if (!pending[tag]) begin
			$display("Result with tag %0d was never accepted or came back twice", tag);
			tag_errors++;
		end else begin
			pending[tag] = 1'b0;
			expected = ref_poly(id, sent_sample[tag]);
			if (out_msg.value !== expected) begin
				$display("ERROR value mismatch: value=%h expected=%h tag=%h core_id=%h",
					out_msg.value, expected, out_msg.tag, out_msg.core_id);
				value_errors++;
			end
			if (tag >= burst_first_tag) begin
				burst_cores[id] = 1'b1;
			end
		end
	endtask

	// Samples settled values just before each rising edge
	initial begin
		forever begin
			@(posedge clk);
			if (!rst) begin
				if (out_valid) begin
					check_result();
				end
				if (accepted - returned > enabled_after(edges)) begin
					$display("More jobs in flight (%0d) than cores enabled (%0d)",
						accepted - returned, enabled_after(edges));
					other_errors++;
				end
				if (in_valid && in_ready) begin
					accepted++;
				end
				edges++;
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout after %0d cycles with %0d of %0d results back",
			TIMEOUT_CYCLES, returned, accepted);
		$display("Verification failed");
		$finish;
	end

	initial begin
		int waited;
		int i;
		int t;
		int assert_errors;
		logic [31:0] bits;
		rst = 1'b1;
		in_valid = 1'b0;
		in_sample = '0;
		lfsr_state = 32'h46fc;
		next_tag = 0;
		burst_first_tag = 256;
		accepted = 0;
		returned = 0;
		edges = 0;
		burst_cores = '0;
		value_errors = 0;
		tag_errors = 0;
		other_errors = 0;
		for (t = 0; t < 256; t++) begin
			pending[t] = 1'b0;
		end
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		for (i = 0; i < RELEASE_SAMPLES; i++) begin
			draw_bits(SAMPLE_W, bits);
			send_sample(sample_t'(bits[SAMPLE_W-1:0]), waited);
			if (i == 0 && waited != RELEASE_GAP) begin
				$display("ERROR in_ready delay after reset: in_ready=%h cycles, expected=%h",
					waited, RELEASE_GAP);
				other_errors++;
			end
		end

		for (i = 0; i < GAP_SAMPLES; i++) begin
			draw_bits(2, bits);
			if (bits[1:0] != 2'b00) begin
				idle_cycles(int'(bits[1:0]));
			end
			draw_bits(SAMPLE_W, bits);
			send_sample(sample_t'(bits[SAMPLE_W-1:0]), waited);
		end

		burst_first_tag = next_tag;
		for (i = 0; i < BURST_SAMPLES; i++) begin
			draw_bits(SAMPLE_W, bits);
			send_sample(sample_t'(bits[SAMPLE_W-1:0]), waited);
		end
		idle_cycles(1);

		while (returned != accepted) begin
			@(negedge clk);
		end
		idle_cycles(4);  // Any stray result shows up here

		for (t = 0; t < next_tag; t++) begin
			if (pending[t % 256]) begin
				$display("Tag %0d was accepted but its result never came back", t);
				tag_errors++;
			end
		end
		if (burst_cores != '1) begin
			$display("Not every core produced a result in the burst, cores seen %b",
				burst_cores);
			other_errors++;
		end
		assert_errors = dut0.asrt0.failures;

		$display("Results %0d of %0d, errors: value %0d tag %0d other %0d assertion %0d",
			returned, next_tag, value_errors, tag_errors, other_errors, assert_errors);
		if (value_errors + tag_errors + other_errors + assert_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
hdl/taylor_types_pkg.sv
hdl/multicore_cfg_pkg.sv
hdl/release_sequencer.sv
hdl/job_dispatcher.sv
hdl/taylor_core.sv
hdl/result_arbiter.sv
hdl/multicore.sv
testbench/multicore_assertions.sv
testbench/multicore_tb.sv

// ==== Makefile ====
TOP = multicore_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
